//--- gen_pulse_pkg.sv
// ----------------------------------------------------------
// Shared widths, MIDI codes, bundle types and constant tables
// for the MIDI-driven pulse generator. Import where needed.
// ----------------------------------------------------------
`default_nettype none

package gen_pulse_pkg;

    localparam int SAMPLE_W   = 18;
    localparam int NOTE_W     = 7;
    localparam int VEL_W      = 7;
    localparam int DIV_W      = 24;
    localparam int COEF_NUM   = 6;
    localparam int IDX_W      = 3;
    localparam int PC_W       = 5;
    localparam int MIDI_CMD_W = 3;

    localparam logic [MIDI_CMD_W-1:0] MIDI_NOTE_OFF = 3'd0;
    localparam logic [MIDI_CMD_W-1:0] MIDI_NOTE_ON  = 3'd1;

    // Velocity to amplitude scaling
    localparam int AMP_SHIFT = 9;

    // Divisor table covers the top octave only
    localparam int BASE_NOTE    = 116;
    localparam int OCTAVE       = 12;
    localparam int BASE_DIV_NUM = 12;

    typedef logic signed [SAMPLE_W-1:0] sample_t;

    typedef struct packed {
        logic [MIDI_CMD_W-1:0] cmd;
        logic [NOTE_W-1:0]     data0;
        logic [VEL_W-1:0]      data1;
    } midi_msg_t;

    typedef struct packed {
        logic              active;
        logic [NOTE_W-1:0] note;
        sample_t           amplitude;
    } note_state_t;

    typedef struct packed {
        logic mul_issue;
        logic out_pos;
        logic out_neg;
        logic clr_note_changed;
        logic clr_period_event;
    } seq_tasks_t;

    typedef struct packed {
        logic    valid;
        sample_t value;
    } out_sample_t;

    // Ramp shape in Q2.16: 0, 1/2, 3/4, 7/8, 15/16, 1
    localparam logic [SAMPLE_W-1:0] COEF_TABLE [COEF_NUM] = '{
        18'h00000, 18'h08000, 18'h0c000, 18'h0e000, 18'h0f000, 18'h10000
    };

    // Notes 116 to 127
    localparam logic [DIV_W-1:0] BASE_DIV [BASE_DIV_NUM] = '{
        24'h001d64, 24'h001bbe, 24'h001a2f, 24'h0018b7,
        24'h001754, 24'h001605, 24'h0014c9, 24'h00139e,
        24'h001284, 24'h00117a, 24'h00107f, 24'h000f92
    };

endpackage

`default_nettype wire

//--- pulse_note_tracker.sv
// ----------------------------------------------------------
// Turns MIDI note-on and note-off strobes into the current
// note state, plus a flag the sequencer clears once seen.
// ----------------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

module pulse_note_tracker (
    input  wire                        clk,
    input  wire                        reset,
    input  wire                        i_midi_valid,
    input  gen_pulse_pkg::midi_msg_t   i_midi,
    input  wire                        i_clr_changed,
    output gen_pulse_pkg::note_state_t o_note,
    output logic                       o_changed
);

    import gen_pulse_pkg::*;

    logic note_on_ev;
    logic note_off_ev;

    assign note_on_ev  = i_midi_valid && (i_midi.cmd == MIDI_NOTE_ON);
    assign note_off_ev = i_midi_valid && (i_midi.cmd == MIDI_NOTE_OFF);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            o_note <= '0;
        end
        else if (note_on_ev) begin
            o_note.active    <= 1'b1;
            o_note.note      <= i_midi.data0;
            o_note.amplitude <= SAMPLE_W'(i_midi.data1) << AMP_SHIFT;
        end
        else if (note_off_ev) begin
            // Note number kept so the period stays defined
            o_note.active    <= 1'b0;
            o_note.amplitude <= '0;
        end
    end

    // New event wins over a clear in the same cycle
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            o_changed <= 1'b0;
        end
        else if (note_on_ev || note_off_ev) begin
            o_changed <= 1'b1;
        end
        else if (i_clr_changed) begin
            o_changed <= 1'b0;
        end
    end

endmodule

`default_nettype wire

//--- pulse_period_timer.sv
// ----------------------------------------------------------
// Per-note period counter. Raises a sticky event each time
// the count reaches the note's divisor; the sequencer uses it
// to end the hold segments and clears it afterwards.
// ----------------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

module pulse_period_timer (
    input  wire                        clk,
    input  wire                        reset,
    input  gen_pulse_pkg::note_state_t i_note,
    input  wire                        i_clr_event,
    output logic                       o_event
);

    import gen_pulse_pkg::*;

    // Octave folding into the table, then one doubling per octave
    function automatic logic [DIV_W-1:0] note_divisor(input logic [NOTE_W-1:0] note);
        logic [NOTE_W-1:0] n;
        logic [3:0]        oct;
        logic [3:0]        slot;
        n   = note;
        oct = '0;
        for (int k = 0; k < 11; k++) begin
            if (n < NOTE_W'(BASE_NOTE)) begin
                n   = n + NOTE_W'(OCTAVE);
                oct = oct + 4'd1;
            end
        end
        slot = 4'(n - NOTE_W'(BASE_NOTE));
        return BASE_DIV[slot] << oct;
    endfunction

    logic [DIV_W-1:0] div;
    logic [DIV_W-1:0] cnt;

    assign div = note_divisor(i_note.note);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            cnt <= '0;
        end
        else if (!i_note.active || (cnt >= div)) begin
            cnt <= '0;
        end
        else begin
            cnt <= cnt + 1'b1;
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            o_event <= 1'b0;
        end
        else if (i_note.active && (cnt == div)) begin
            o_event <= 1'b1;
        end
        else if (i_clr_event) begin
            o_event <= 1'b0;
        end
    end

endmodule

`default_nettype wire

//--- pulse_sequencer.sv
// ----------------------------------------------------------
// Microsequencer for the trapezoid wave. A fixed 21-step
// program drives the index register and issues the task
// flags for the edge store and the two flag owners.
// ----------------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

module pulse_sequencer (
    input  wire                               clk,
    input  wire                               reset,
    input  wire                               i_sample_trig,
    input  wire                               i_note_changed,
    input  wire                               i_period_event,
    output gen_pulse_pkg::seq_tasks_t         o_tasks,
    output logic [gen_pulse_pkg::IDX_W-1:0]   o_index
);

    import gen_pulse_pkg::*;

    localparam logic [IDX_W-1:0] IDX_LAST = IDX_W'(COEF_NUM - 1);

    // Flags used only inside the sequencer
    typedef struct packed {
        logic clr_i;
        logic inc_i;
        logic dec_i;
        logic jp_0;
        logic jp_2;
        logic jp_up2;
        logic rep_coef;
        logic wait_trig;
    } ctrl_t;

    logic [PC_W-1:0]  pc;
    logic [IDX_W-1:0] rep_cnt;
    logic [IDX_W-1:0] rep_max;
    logic             rep_busy;
    ctrl_t            ctrl;

    // ------------------------------------------------------
    // Program
    // ------------------------------------------------------
    always_comb begin
        ctrl    = '0;
        o_tasks = '0;
        case (pc)
            // Period start, recompute only on a note change
            5'd0: begin
                ctrl.clr_i = 1'b1;
                if (i_note_changed) begin
                    o_tasks.clr_note_changed = 1'b1;
                end
                else begin
                    ctrl.jp_2 = 1'b1;
                end
            end
            5'd1: begin
                ctrl.rep_coef     = 1'b1;
                o_tasks.mul_issue = 1'b1;
                if (o_index != IDX_LAST) begin
                    ctrl.inc_i = 1'b1;
                end
                else begin
                    ctrl.clr_i = 1'b1;
                end
            end
            // Rise
            5'd2:  ctrl.wait_trig = 1'b1;
            5'd3:  o_tasks.out_pos = 1'b1;
            5'd4: begin
                if (o_index != IDX_LAST) begin
                    ctrl.inc_i  = 1'b1;
                    ctrl.jp_up2 = 1'b1;
                end
            end
            // Hold
            5'd5:  ctrl.wait_trig = 1'b1;
            5'd6:  o_tasks.out_pos = 1'b1;
            5'd7: begin
                if (!i_period_event) begin
                    ctrl.jp_up2 = 1'b1;
                end
                else begin
                    o_tasks.clr_period_event = 1'b1;
                end
            end
            // Fall back to zero
            5'd8:  ctrl.wait_trig = 1'b1;
            5'd9:  o_tasks.out_pos = 1'b1;
            5'd10: begin
                ctrl.inc_i  = (o_index == '0);
                ctrl.dec_i  = (o_index != '0);
                ctrl.jp_up2 = (o_index != '0);
            end
            // Negative rise
            5'd11: ctrl.wait_trig = 1'b1;
            5'd12: o_tasks.out_neg = 1'b1;
            5'd13: begin
                if (o_index != IDX_LAST) begin
                    ctrl.inc_i  = 1'b1;
                    ctrl.jp_up2 = 1'b1;
                end
            end
            // Negative hold
            5'd14: ctrl.wait_trig = 1'b1;
            5'd15: o_tasks.out_neg = 1'b1;
            5'd16: begin
                if (!i_period_event) begin
                    ctrl.jp_up2 = 1'b1;
                end
                else begin
                    o_tasks.clr_period_event = 1'b1;
                end
            end
            // Negative fall, stops short of zero
            5'd17: ctrl.wait_trig = 1'b1;
            5'd18: o_tasks.out_neg = 1'b1;
            5'd19: begin
                if (o_index != IDX_W'(1)) begin
                    ctrl.dec_i  = 1'b1;
                    ctrl.jp_up2 = 1'b1;
                end
            end
            default: ctrl.jp_0 = 1'b1;
        endcase
    end

    // ------------------------------------------------------
    // Program counter and repeat counter
    // ------------------------------------------------------
    assign rep_max  = ctrl.rep_coef ? IDX_LAST : '0;
    assign rep_busy = (rep_cnt != rep_max);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            pc <= '0;
        end
        else if (ctrl.jp_0) begin
            pc <= '0;
        end
        else if (ctrl.jp_2) begin
            pc <= PC_W'(2);
        end
        else if (ctrl.jp_up2) begin
            pc <= pc - PC_W'(2);
        end
        else if (!((ctrl.wait_trig && !i_sample_trig) || (ctrl.rep_coef && rep_busy))) begin
            pc <= pc + PC_W'(1);
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            rep_cnt <= '0;
        end
        else if (rep_busy) begin
            rep_cnt <= rep_cnt + 1'b1;
        end
        else begin
            rep_cnt <= '0;
        end
    end

    // Index register
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            o_index <= '0;
        end
        else if (ctrl.clr_i) begin
            o_index <= '0;
        end
        else if (ctrl.inc_i) begin
            o_index <= o_index + 1'b1;
        end
        else if (ctrl.dec_i) begin
            o_index <= o_index - 1'b1;
        end
    end

endmodule

`default_nettype wire

//--- pulse_edge_store.sv
// ----------------------------------------------------------
// Scales the ramp coefficients by the note amplitude through
// a pipelined multiply, keeps the results in a small sample
// array and drives the signed output sample register.
// ----------------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

module pulse_edge_store #(
    parameter int MUL_STAGES = 3
) (
    input  wire                             clk,
    input  wire                             reset,
    input  gen_pulse_pkg::seq_tasks_t       i_tasks,
    input  wire [gen_pulse_pkg::IDX_W-1:0]  i_index,
    input  gen_pulse_pkg::sample_t          i_amplitude,
    output gen_pulse_pkg::out_sample_t      o_sample
);

    import gen_pulse_pkg::*;

    localparam int PROD_W = 2 * SAMPLE_W;
    localparam int FRAC_W = 16;

    typedef struct packed {
        logic [IDX_W-1:0]  idx;
        logic [PROD_W-1:0] prod;
    } mul_word_t;

    logic signed [SAMPLE_W-1:0] coef;
    logic signed [PROD_W-1:0]   mul_prod;
    logic [MUL_STAGES-1:0]      pipe_vld;
    mul_word_t                  pipe [MUL_STAGES];
    sample_t                    smpl_arr [COEF_NUM];
    sample_t                    sel;

    assign coef     = $signed(COEF_TABLE[i_index]);
    assign mul_prod = coef * i_amplitude;

    // ------------------------------------------------------
    // Multiply pipeline
    // ------------------------------------------------------
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            pipe_vld <= '0;
        end
        else begin
            pipe_vld[0] <= i_tasks.mul_issue;
            for (int s = 1; s < MUL_STAGES; s++) begin
                pipe_vld[s] <= pipe_vld[s-1];
            end
        end
    end

    always_ff @(posedge clk) begin
        pipe[0].idx  <= i_index;
        pipe[0].prod <= mul_prod;
        for (int s = 1; s < MUL_STAGES; s++) begin
            pipe[s] <= pipe[s-1];
        end
    end

    // Silent until the first note has been computed
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int k = 0; k < COEF_NUM; k++) begin
                smpl_arr[k] <= '0;
            end
        end
        else if (pipe_vld[MUL_STAGES-1]) begin
            smpl_arr[pipe[MUL_STAGES-1].idx] <= pipe[MUL_STAGES-1].prod[FRAC_W +: SAMPLE_W];
        end
    end

    // ------------------------------------------------------
    // Output register
    // ------------------------------------------------------
    assign sel = smpl_arr[i_index];

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            o_sample <= '0;
        end
        else if (i_tasks.out_pos) begin
            o_sample.valid <= 1'b1;
            o_sample.value <= sel;
        end
        else if (i_tasks.out_neg) begin
            o_sample.valid <= 1'b1;
            o_sample.value <= -sel;
        end
        else begin
            o_sample <= '0;
        end
    end

endmodule

`default_nettype wire

//--- gen_pulse.sv
// ----------------------------------------------------------
// MIDI pulse generator top level. One mono sample comes out
// for each sample trigger the sequencer accepts.
// ----------------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

module gen_pulse #(
    parameter int MUL_STAGES = 3
) (
    input  wire                         clk,
    input  wire                         reset,
    input  wire                         i_midi_valid,
    input  gen_pulse_pkg::midi_msg_t    i_midi,
    input  wire                         i_sample_trig,
    output gen_pulse_pkg::out_sample_t  o_sample
);

    import gen_pulse_pkg::*;

    note_state_t      note;
    logic             note_changed;
    logic             period_event;
    seq_tasks_t       tasks;
    logic [IDX_W-1:0] index;

    pulse_note_tracker u_note_tracker (
        .clk           (clk),
        .reset         (reset),
        .i_midi_valid  (i_midi_valid),
        .i_midi        (i_midi),
        .i_clr_changed (tasks.clr_note_changed),
        .o_note        (note),
        .o_changed     (note_changed)
    );

    pulse_period_timer u_period_timer (
        .clk         (clk),
        .reset       (reset),
        .i_note      (note),
        .i_clr_event (tasks.clr_period_event),
        .o_event     (period_event)
    );

    pulse_sequencer u_sequencer (
        .clk            (clk),
        .reset          (reset),
        .i_sample_trig  (i_sample_trig),
        .i_note_changed (note_changed),
        .i_period_event (period_event),
        .o_tasks        (tasks),
        .o_index        (index)
    );

    pulse_edge_store #(
        .MUL_STAGES (MUL_STAGES)
    ) u_edge_store (
        .clk         (clk),
        .reset       (reset),
        .i_tasks     (tasks),
        .i_index     (index),
        .i_amplitude (note.amplitude),
        .o_sample    (o_sample)
    );

endmodule

`default_nettype wire

//--- gen_pulse_checker.sv
// ----------------------------------------------------------
// Protocol assertions on the output sample, bound into the
// pulse generator top level.
// ----------------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

module gen_pulse_checker (
    input wire                           clk,
    input wire                           reset,
    input wire                           i_sample_trig,
    input wire [gen_pulse_pkg::PC_W-1:0] i_pc,
    input gen_pulse_pkg::out_sample_t    i_sample
);

    import gen_pulse_pkg::*;

    logic wait_st;

    // Trigger wait states of the program
    assign wait_st = (i_pc == 5'd2) || (i_pc == 5'd5) || (i_pc == 5'd8)
                  || (i_pc == 5'd11) || (i_pc == 5'd14) || (i_pc == 5'd17);

    a_reset_quiet: assert property (@(posedge clk)
        $fell(reset) |-> (i_sample == '0) ##1 (i_sample == '0) ##1 (i_sample == '0))
    else $error("output not quiet after reset");

    a_single_valid: assert property (@(posedge clk) disable iff (reset)
        i_sample.valid |=> !i_sample.valid)
    else $error("valid high on consecutive cycles");

    a_zero_idle: assert property (@(posedge clk) disable iff (reset)
        !i_sample.valid |-> (i_sample.value == '0))
    else $error("nonzero value while valid is low");

    a_trig_valid: assert property (@(posedge clk) disable iff (reset)
        (wait_st && i_sample_trig) |-> ##2 i_sample.valid)
    else $error("no sample two cycles after an accepted trigger");

endmodule

bind gen_pulse gen_pulse_checker u_checker (
    .clk           (clk),
    .reset         (reset),
    .i_sample_trig (i_sample_trig),
    .i_pc          (u_sequencer.pc),
    .i_sample      (o_sample)
);

`default_nettype wire

//--- gen_pulse_tb.sv
// ----------------------------------------------------------
// Testbench for the MIDI pulse generator. Random triggers and
// velocities, a negedge sample monitor with immediate checks.
// ----------------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

module gen_pulse_tb;

    import gen_pulse_pkg::*;

    localparam int TIMEOUT_CYCLES = 200000;
    localparam logic [31:0] LFSR_SEED = 32'h7d9f_3ae9;
    localparam int C_PERIOD = 0;
    localparam int C_RISE   = 1;
    localparam int C_PEAK   = 2;
    localparam int C_NFALL  = 3;
    localparam int C_ZERO   = 4;

    logic        clk = 1'b0;
    logic        reset;
    logic        i_midi_valid;
    midi_msg_t   i_midi;
    logic        i_sample_trig;
    out_sample_t o_sample;

    logic [31:0] lfsr_state;
    logic        trig_run;
    int          gap;
    int          tb_vel;
    int          cur_vel;
    int          rise_cnt;
    int          prev_v;
    int          prev_sign;
    logic        pos_seen;
    logic        neg_seen;
    logic        period_open;
    int          cnt [5];

    gen_pulse #(.MUL_STAGES(3)) i_dut (
        .clk           (clk),
        .reset         (reset),
        .i_midi_valid  (i_midi_valid),
        .i_midi        (i_midi),
        .i_sample_trig (i_sample_trig),
        .o_sample      (o_sample)
    );

    always #50 clk = ~clk;

    // Fibonacci LFSR with taps 32 22 2 1
    function automatic int take_bits(input int n);
        int   r;
        logic fb;
        r = 0;
        for (int i = 0; i < n; i++) begin
            fb         = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
            lfsr_state = {lfsr_state[30:0], fb};
            r          = (r << 1) | int'(fb);
        end
        return r;
    endfunction

    // Expected sample k of the rise for a velocity
    function automatic int model_value(input int vel, input int k);
        int amp;
        amp = vel * 512;
        case (k)
            0:       return 0;
            1:       return amp / 2;
            2:       return (amp * 3) / 4;
            3:       return (amp * 7) / 8;
            4:       return (amp * 15) / 16;
            default: return amp;
        endcase
    endfunction

    task automatic mismatch_stop(input string name, input int exp, input int act);
        $display("[FAIL] %s expected %0d actual %0d", name, exp, act);
        $display("TB FAILED");
        $fatal(1, "value check failed");
    endtask

    task automatic error_stop(input string msg);
        $display("Error: %s", msg);
        $display("TB FAILED");
        $fatal(1, "check failed");
    endtask

    task automatic wait_count(input int sel, input int target, input string what);
        int cycles;
        cycles = 0;
        while (cnt[sel] < target) begin
            @(posedge clk);
            cycles++;
            if (cycles > TIMEOUT_CYCLES) begin
                error_stop({"timeout waiting for ", what});
            end
        end
    endtask

    task automatic send_note(input logic on, input int note, input int vel);
        i_midi_valid <= 1'b1;
        i_midi       <= {(on ? MIDI_NOTE_ON : MIDI_NOTE_OFF), NOTE_W'(note), VEL_W'(vel)};
        tb_vel       = on ? vel : 0;
        @(posedge clk);
        i_midi_valid <= 1'b0;
    endtask

    function automatic int pick_vel(input int old);
        int v;
        v = (take_bits(7) % 112) + 16;
        return (v == old) ? (v ^ 1) : v;
    endfunction

    // One-cycle trigger pulses 4 to 11 cycles apart
    always begin
        @(negedge clk);
        if (trig_run) begin
            gap = 4 + take_bits(3);
            repeat (gap) @(posedge clk);
            i_sample_trig <= 1'b1;
            @(posedge clk);
            i_sample_trig <= 1'b0;
        end
    end

    // ------------------------------------------------------
    // Sample monitor
    // ------------------------------------------------------
    always @(negedge clk) begin
        int   v;
        int   sgn;
        logic hit;
        if (!reset) begin
            if (i_dut.u_sequencer.pc == '0) begin
                if (period_open) begin
                    assert (pos_seen && neg_seen)
                    else error_stop("period ended without both peaks");
                end
                period_open = 1'b1;
                cur_vel     = tb_vel;
                rise_cnt    = 0;
                pos_seen    = 1'b0;
                neg_seen    = 1'b0;
                cnt[C_PERIOD]++;
            end
            if (o_sample.valid) begin
                v   = int'($signed(o_sample.value));
                sgn = (v > 0) ? 1 : ((v < 0) ? -1 : 0);
                hit = 1'b0;
                for (int k = 0; k < COEF_NUM; k++) begin
                    if (v == model_value(cur_vel, k) || v == -model_value(cur_vel, k)) begin
                        hit = 1'b1;
                    end
                end
                assert (hit) else mismatch_stop("value_set_peak", model_value(cur_vel, 5), v);
                if (rise_cnt < COEF_NUM) begin
                    assert (v == model_value(cur_vel, rise_cnt))
                    else mismatch_stop("rise_order", model_value(cur_vel, rise_cnt), v);
                    rise_cnt++;
                    if (rise_cnt == COEF_NUM && cur_vel != 0) cnt[C_RISE]++;
                end
                assert (!(prev_sign != 0 && sgn == -prev_sign))
                else error_stop("sign changed without a zero sample");
                if (v == model_value(cur_vel, 5)) begin
                    pos_seen = 1'b1;
                    if (cur_vel != 0) cnt[C_PEAK]++;
                end
                if (v == -model_value(cur_vel, 5)) neg_seen = 1'b1;
                if (cur_vel != 0 && v == -model_value(cur_vel, 4)
                        && prev_v == -model_value(cur_vel, 5)) begin
                    cnt[C_NFALL]++;
                end
                if (cur_vel == 0) cnt[C_ZERO]++;
                prev_v    = v;
                prev_sign = sgn;
            end
        end
    end

    initial begin
        int v1;
        int v2;
        reset         = 1'b1;
        i_midi_valid  = 1'b0;
        i_midi        = '0;
        i_sample_trig = 1'b0;
        trig_run      = 1'b0;
        lfsr_state    = LFSR_SEED;
        tb_vel        = 0;
        cur_vel       = 0;
        rise_cnt      = 0;
        prev_v        = 0;
        prev_sign     = 0;
        pos_seen      = 1'b0;
        neg_seen      = 1'b0;
        period_open   = 1'b0;
        for (int i = 0; i < 5; i++) begin
            cnt[i] = 0;
        end
        repeat (5) @(posedge clk);
        reset <= 1'b0;
        repeat (3) @(posedge clk);
        trig_run <= 1'b1;

        // First note over full periods
        v1 = pick_vel(0);
        send_note(1'b1, 120 + take_bits(3), v1);
        wait_count(C_RISE, cnt[C_RISE] + 1, "first rise");
        wait_count(C_PERIOD, cnt[C_PERIOD] + 2, "full period");

        // Velocity change in the middle of the wave
        wait_count(C_PEAK, cnt[C_PEAK] + 1, "positive peak");
        v2 = pick_vel(v1);
        send_note(1'b1, 120 + take_bits(3), v2);
        wait_count(C_RISE, cnt[C_RISE] + 1, "rise after change");
        wait_count(C_PERIOD, cnt[C_PERIOD] + 1, "period after change");

        // Note-off during the negative fall
        wait_count(C_NFALL, cnt[C_NFALL] + 1, "negative fall");
        send_note(1'b0, 0, 0);
        wait_count(C_ZERO, cnt[C_ZERO] + 12, "silent samples");

        send_note(1'b1, 120 + take_bits(3), pick_vel(0));
        wait_count(C_RISE, cnt[C_RISE] + 1, "rise after note-off");
        wait_count(C_PERIOD, cnt[C_PERIOD] + 1, "last period");

        $display("TB PASSED");
        $finish;
    end

endmodule

`default_nettype wire

//--- gen_pulse.f
gen_pulse_pkg.sv
pulse_note_tracker.sv
pulse_period_timer.sv
pulse_sequencer.sv
pulse_edge_store.sv
gen_pulse.sv
gen_pulse_checker.sv
gen_pulse_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= gen_pulse_tb
FILELIST  ?= gen_pulse.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0

SRCS := $(shell grep -v '^+' $(FILELIST))
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN)

clean:
	rm -rf $(OBJ_DIR)
